/* hw/net_proto_pkg.sv */
package net_proto_pkg;

    // --------------------
    // protocol field values
    localparam logic [15:0] eth_type_ipv4     = 16'h0800;
    localparam logic [7:0]  ip_ver_ihl        = 8'h45;     // ipv4, 5 words
    localparam logic [15:0] ip_flags_frag     = 16'h4000;  // df set, offset 0
    localparam logic [7:0]  ip_ttl            = 8'h80;
    localparam logic [7:0]  ip_proto_icmp     = 8'h01;
    localparam logic [7:0]  icmp_echo_reply   = 8'h00;

    // 20 byte ip header plus 8 byte icmp header
    localparam logic [15:0] ip_icmp_hdr_bytes = 16'd28;
    // 46 byte ethernet minimum less the two headers
    localparam logic [15:0] min_payload_bytes = 16'd18;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // --------------------
    // header record, words[0] goes out first
    // words 0..4 are the ip header, 5..6 the icmp header
    typedef struct packed {
        mac_addr_t         dst_mac;
        logic [0:6][31:0]  words;
        logic [15:0]       payload_len;
    } echo_hdr_t;

endpackage

/* hw/gmii_frame_pkg.sv */
package gmii_frame_pkg;

    typedef enum logic [2:0] {
        ph_idle,
        ph_preamble,
        ph_eth_hdr,
        ph_ip_hdr,
        ph_payload,
        ph_fcs
    } frame_phase_t;

    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hd5;
    localparam logic [15:0] preamble_len  = 16'd8;   // includes the sfd
    localparam logic [15:0] eth_hdr_len   = 16'd14;

    // reflected crc-32, one byte lsb first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ 32'hedb8_8320;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

/* hw/echo_hdr_if.sv */
`timescale 1ns/100ps

interface echo_hdr_if;
    import net_proto_pkg::*;

    logic      req;
    logic      ack;
    echo_hdr_t hdr;    // held stable while req is high

    modport builder (
        output req,
        output hdr,
        input  ack
    );

    modport framer (
        input  req,
        input  hdr,
        output ack
    );

endinterface

/* hw/echo_header_builder.sv */
`timescale 1ns/100ps

module echo_header_builder #(
    parameter net_proto_pkg::ip_addr_t  board_ip        = {8'd192, 8'd168, 8'd0, 8'd2},
    parameter net_proto_pkg::mac_addr_t default_dst_mac = 48'hff_ff_ff_ff_ff_ff,
    parameter net_proto_pkg::ip_addr_t  default_dst_ip  = {8'd192, 8'd168, 8'd0, 8'd3}
) (
    input  logic                      gmii_tx_clk,
    input  logic                      rst,
    input  logic                      tx_start,
    input  logic [15:0]               tx_byte_num,
    input  net_proto_pkg::mac_addr_t  dst_mac,
    input  net_proto_pkg::ip_addr_t   dst_ip,
    input  logic [15:0]               icmp_id,
    input  logic [15:0]               icmp_seq,
    input  logic [31:0]               data_sum,
    input  logic                      frame_done,
    output logic                      busy,
    echo_hdr_if.builder               hdr_port
);
    import net_proto_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_ip_sum,
        st_icmp_sum,
        st_req,
        st_release,
        st_wait_done
    } build_state_t;

    build_state_t state;
    logic [1:0]   step;        // checksum sub-cycle
    logic [15:0]  ip_id;
    logic         accept;

    logic [15:0]  len_q;
    logic [15:0]  total_len;
    mac_addr_t    mac_q;
    ip_addr_t     ip_q;
    logic [15:0]  id_q;
    logic [15:0]  seq_q;
    logic [31:0]  data_sum_q;
    logic [31:0]  sum;
    logic [15:0]  ip_csum;
    logic [15:0]  icmp_csum;

    function automatic logic [31:0] ext(input logic [15:0] w);
        return {16'h0000, w};
    endfunction

    // busy drops in the same cycle as frame_done
    assign busy   = (state != st_idle) && !frame_done;
    assign accept = tx_start && !busy;

    // --------------------
    // control
    always_ff @(posedge gmii_tx_clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            step         <= 2'd0;
            ip_id        <= 16'd0;
            hdr_port.req <= 1'b0;
        end else if (accept) begin
            state <= st_ip_sum;
            step  <= 2'd0;
            ip_id <= ip_id + 16'd1;    // first frame carries 1
        end else begin
            case (state)
                st_ip_sum: begin
                    step <= step + 2'd1;
                    if (step == 2'd3)
                        state <= st_icmp_sum;
                end
                st_icmp_sum: begin
                    step <= step + 2'd1;
                    if (step == 2'd3)
                        state <= st_req;
                end
                st_req: begin
                    if (!hdr_port.req) begin
                        if (!hdr_port.ack)          // previous handshake fully closed
                            hdr_port.req <= 1'b1;
                    end else if (hdr_port.ack) begin
                        hdr_port.req <= 1'b0;
                        state        <= st_release;
                    end
                end
                st_release: if (!hdr_port.ack) state <= st_wait_done;
                st_wait_done: if (frame_done) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // --------------------
    // request fields and checksums
    always_ff @(posedge gmii_tx_clk) begin
        if (accept) begin
            len_q      <= tx_byte_num;
            total_len  <= tx_byte_num + ip_icmp_hdr_bytes;
            mac_q      <= (dst_mac != '0) ? dst_mac : default_dst_mac;
            ip_q       <= (dst_ip != '0) ? dst_ip : default_dst_ip;
            id_q       <= icmp_id;
            seq_q      <= icmp_seq;
            data_sum_q <= data_sum;
        end
        if (state == st_ip_sum) begin
            case (step)
                2'd0: sum <= ext({ip_ver_ihl, 8'h00}) + ext(total_len) + ext(ip_id)
                             + ext(ip_flags_frag) + ext({ip_ttl, ip_proto_icmp})
                             + ext(board_ip[31:16]) + ext(board_ip[15:0])
                             + ext(ip_q[31:16]) + ext(ip_q[15:0]);
                2'd3: ip_csum <= ~sum[15:0];
                default: sum <= ext(sum[31:16]) + ext(sum[15:0]);   // end-around carry
            endcase
        end else if (state == st_icmp_sum) begin
            case (step)
                2'd0: sum <= ext({icmp_echo_reply, 8'h00}) + ext(id_q) + ext(seq_q)
                             + data_sum_q;
                2'd3: icmp_csum <= ~sum[15:0];
                default: sum <= ext(sum[31:16]) + ext(sum[15:0]);
            endcase
        end
    end

    // field order matches echo_hdr_t
    assign hdr_port.hdr = {
        mac_q,
        ip_ver_ihl, 8'h00, total_len,            // tos 0
        ip_id, ip_flags_frag,
        ip_ttl, ip_proto_icmp, ip_csum,
        board_ip,
        ip_q,
        icmp_echo_reply, 8'h00, icmp_csum,       // code 0
        id_q, seq_q,
        len_q
    };

endmodule

/* hw/payload_fifo.sv */
`timescale 1ns/100ps

module payload_fifo #(
    parameter int fifo_depth = 64    // power of two
) (
    input  logic                        gmii_tx_clk,
    input  logic                        rst,
    input  logic                        wr,
    input  logic [7:0]                  wdata,
    output logic                        full,
    input  logic                        rd,
    output logic [7:0]                  rdata,
    output logic [$clog2(fifo_depth):0] count
);
    localparam int aw = $clog2(fifo_depth);

    logic [7:0]    mem [fifo_depth];
    logic [aw-1:0] wptr;
    logic [aw-1:0] rptr;
    logic          wr_ok;
    logic          rd_ok;

    assign full  = count == fifo_depth[aw:0];
    assign wr_ok = wr && !full;
    assign rd_ok = rd && (count != '0);

    // pointers wrap on their own
    always_ff @(posedge gmii_tx_clk or posedge rst) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_ok)
                wptr <= wptr + 1'b1;
            if (rd_ok)
                rptr <= rptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        if (wr_ok)
            mem[wptr] <= wdata;
        if (rd_ok)
            rdata <= mem[rptr];    // valid the cycle after rd
    end

endmodule

/* hw/gmii_frame_tx.sv */
`timescale 1ns/100ps

module gmii_frame_tx #(
    parameter net_proto_pkg::mac_addr_t board_mac  = 48'h00_11_22_33_44_55,
    parameter int                       fifo_depth = 64
) (
    input  logic                        gmii_tx_clk,
    input  logic                        rst,
    echo_hdr_if.framer                  hdr_port,
    output logic                        fifo_rd,
    input  logic [7:0]                  fifo_data,
    input  logic [$clog2(fifo_depth):0] fifo_count,
    output logic                        gmii_tx_en,
    output logic [7:0]                  gmii_txd,
    output logic                        frame_done
);
    import net_proto_pkg::*;
    import gmii_frame_pkg::*;

    frame_phase_t phase;
    logic [15:0]  cnt;          // byte index within the phase
    logic [31:0]  crc;
    echo_hdr_t    hdr_q;
    logic [111:0] eth_hdr;
    logic [15:0]  pay_total;    // payload plus pad
    logic [31:0]  word;
    logic         rd_valid;
    logic         tx_en_q;
    logic         start;
    logic         last_byte;
    logic [7:0]   tx_byte;

    assign eth_hdr   = {hdr_q.dst_mac, board_mac, eth_type_ipv4};
    assign pay_total = (hdr_q.payload_len > min_payload_bytes) ? hdr_q.payload_len
                                                               : min_payload_bytes;
    assign word      = hdr_q.words[cnt[4:2]];
    assign start     = (phase == ph_idle) && hdr_port.req && !hdr_port.ack;

    // fetch one byte ahead so it lines up with the send slot
    assign fifo_rd = (fifo_count != '0) &&
                     (((phase == ph_ip_hdr) && (cnt == 16'd27) && (hdr_q.payload_len != 16'd0)) ||
                      ((phase == ph_payload) && (cnt + 16'd1 < hdr_q.payload_len)));

    // --------------------
    // byte mux
    always_comb begin
        tx_byte   = 8'h00;
        last_byte = 1'b0;
        case (phase)
            ph_preamble: begin
                last_byte = cnt == preamble_len - 16'd1;
                tx_byte   = last_byte ? sfd_byte : preamble_byte;
            end
            ph_eth_hdr: begin
                tx_byte   = eth_hdr[8 * (eth_hdr_len - 16'd1 - cnt) +: 8];
                last_byte = cnt == eth_hdr_len - 16'd1;
            end
            ph_ip_hdr: begin
                tx_byte   = word[8 * (3 - cnt[1:0]) +: 8];    // msb first
                last_byte = cnt == {11'd0, ip_icmp_hdr_bytes[4:0]} - 16'd1;
            end
            ph_payload: begin
                tx_byte   = rd_valid ? fifo_data : 8'h00;     // zero pad past n
                last_byte = cnt == pay_total - 16'd1;
            end
            ph_fcs: begin
                tx_byte   = ~crc[8 * cnt[1:0] +: 8];           // low byte first
                last_byte = cnt == 16'd3;
            end
            default: ;
        endcase
    end

    // --------------------
    // phase sequencing
    always_ff @(posedge gmii_tx_clk or posedge rst) begin
        if (rst) begin
            phase        <= ph_idle;
            cnt          <= 16'd0;
            crc          <= '1;
            hdr_port.ack <= 1'b0;
            rd_valid     <= 1'b0;
            gmii_tx_en   <= 1'b0;
            tx_en_q      <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            rd_valid   <= fifo_rd;
            gmii_tx_en <= phase != ph_idle;
            tx_en_q    <= gmii_tx_en;
            frame_done <= tx_en_q && !gmii_tx_en;    // one cycle after en falls

            if (hdr_port.ack && !hdr_port.req)
                hdr_port.ack <= 1'b0;

            if (phase == ph_idle) begin
                cnt <= 16'd0;
                crc <= '1;
                if (start) begin
                    hdr_port.ack <= 1'b1;
                    phase        <= ph_preamble;
                end
            end else begin
                if (phase == ph_eth_hdr || phase == ph_ip_hdr || phase == ph_payload)
                    crc <= crc32_step(crc, tx_byte);
                if (last_byte) begin
                    cnt <= 16'd0;
                    case (phase)
                        ph_preamble: phase <= ph_eth_hdr;
                        ph_eth_hdr:  phase <= ph_ip_hdr;
                        ph_ip_hdr:   phase <= ph_payload;
                        ph_payload:  phase <= ph_fcs;
                        default:     phase <= ph_idle;
                    endcase
                end else begin
                    cnt <= cnt + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        if (start)
            hdr_q <= hdr_port.hdr;
        gmii_txd <= tx_byte;
    end

endmodule

/* hw/icmp_echo_tx.sv */
`timescale 1ns/100ps

module icmp_echo_tx #(
    parameter net_proto_pkg::mac_addr_t board_mac       = 48'h00_11_22_33_44_55,
    parameter net_proto_pkg::ip_addr_t  board_ip        = {8'd192, 8'd168, 8'd0, 8'd2},
    parameter net_proto_pkg::mac_addr_t default_dst_mac = 48'hff_ff_ff_ff_ff_ff,
    parameter net_proto_pkg::ip_addr_t  default_dst_ip  = {8'd192, 8'd168, 8'd0, 8'd3},
    parameter int                       fifo_depth      = 64
) (
    input  logic                      gmii_tx_clk,
    input  logic                      rst,
    // echo request
    input  logic                      tx_start,
    input  logic [15:0]               tx_byte_num,
    input  net_proto_pkg::mac_addr_t  dst_mac,
    input  net_proto_pkg::ip_addr_t   dst_ip,
    input  logic [15:0]               icmp_id,
    input  logic [15:0]               icmp_seq,
    input  logic [31:0]               data_sum,     // unfolded payload sum
    // payload fill
    input  logic [7:0]                payload_data,
    input  logic                      payload_wr,
    output logic                      payload_full,
    // gmii
    output logic                      gmii_tx_en,
    output logic [7:0]                gmii_txd,
    output logic                      busy,
    output logic                      tx_done
);
    logic                        fifo_rd;
    logic [7:0]                  fifo_data;
    logic [$clog2(fifo_depth):0] fifo_count;

    echo_hdr_if hdr_bus ();

    echo_header_builder #(
        .board_ip        (board_ip),
        .default_dst_mac (default_dst_mac),
        .default_dst_ip  (default_dst_ip)
    ) u_builder (
        .gmii_tx_clk (gmii_tx_clk),
        .rst         (rst),
        .tx_start    (tx_start),
        .tx_byte_num (tx_byte_num),
        .dst_mac     (dst_mac),
        .dst_ip      (dst_ip),
        .icmp_id     (icmp_id),
        .icmp_seq    (icmp_seq),
        .data_sum    (data_sum),
        .frame_done  (tx_done),
        .busy        (busy),
        .hdr_port    (hdr_bus.builder)
    );

    payload_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .gmii_tx_clk (gmii_tx_clk),
        .rst         (rst),
        .wr          (payload_wr),
        .wdata       (payload_data),
        .full        (payload_full),
        .rd          (fifo_rd),
        .rdata       (fifo_data),
        .count       (fifo_count)
    );

    gmii_frame_tx #(
        .board_mac  (board_mac),
        .fifo_depth (fifo_depth)
    ) u_framer (
        .gmii_tx_clk (gmii_tx_clk),
        .rst         (rst),
        .hdr_port    (hdr_bus.framer),
        .fifo_rd     (fifo_rd),
        .fifo_data   (fifo_data),
        .fifo_count  (fifo_count),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .frame_done  (tx_done)     // completion pulse goes straight out
    );

endmodule

/* verification/icmp_echo_tx_tb.sv */
`timescale 1ns/100ps

module icmp_echo_tx_tb;

    localparam logic [47:0] board_mac       = 48'h02_00_00_aa_bb_cc;
    localparam logic [31:0] board_ip        = {8'd10, 8'd0, 8'd0, 8'd2};
    localparam logic [47:0] default_dst_mac = 48'h02_00_00_11_22_33;
    localparam logic [31:0] default_dst_ip  = {8'd10, 8'd0, 8'd0, 8'd9};
    localparam int          num_frames      = 3;

    logic        gmii_tx_clk;
    logic        rst;
    logic        tx_start;
    logic [15:0] tx_byte_num;
    logic [47:0] dst_mac;
    logic [31:0] dst_ip;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
    logic [31:0] data_sum;
    logic [7:0]  payload_data;
    logic        payload_wr;
    logic        payload_full;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;
    logic        busy;
    logic        tx_done;

    integer      seed = 1289;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    logic [7:0]  cap [$];        // bytes seen while gmii_tx_en is high
    logic [7:0]  payload [$];    // bytes written into the fifo

    icmp_echo_tx #(
        .board_mac       (board_mac),
        .board_ip        (board_ip),
        .default_dst_mac (default_dst_mac),
        .default_dst_ip  (default_dst_ip),
        .fifo_depth      (64)
    ) UUT (
        .gmii_tx_clk  (gmii_tx_clk),
        .rst          (rst),
        .tx_start     (tx_start),
        .tx_byte_num  (tx_byte_num),
        .dst_mac      (dst_mac),
        .dst_ip       (dst_ip),
        .icmp_id      (icmp_id),
        .icmp_seq     (icmp_seq),
        .data_sum     (data_sum),
        .payload_data (payload_data),
        .payload_wr   (payload_wr),
        .payload_full (payload_full),
        .gmii_tx_en   (gmii_tx_en),
        .gmii_txd     (gmii_txd),
        .busy         (busy),
        .tx_done      (tx_done)
    );

    always #50 gmii_tx_clk = ~gmii_tx_clk;

    always @(negedge gmii_tx_clk) begin
        if (gmii_tx_en)
            cap.push_back(gmii_txd);
    end

    // --------------------
    // tx_done timing
    done_follows_frame: assert property (
        @(posedge gmii_tx_clk) disable iff (rst) $fell(gmii_tx_en) |=> tx_done
    ) else begin
        errors++;
        $display("tx_done did not pulse one cycle after gmii_tx_en fell");
    end

    done_only_after_frame: assert property (
        @(posedge gmii_tx_clk) disable iff (rst)
            tx_done |-> !$past(gmii_tx_en) && $past(gmii_tx_en, 2)
    ) else begin
        errors++;
        $display("tx_done pulsed without a frame ending just before it");
    end

    task automatic check_equal(input string name, input logic [47:0] exp, input logic [47:0] act);
        assert (act == exp)
        else begin
            $display("ERROR %s: expected %0h, got %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    // big endian field out of the captured frame
    function automatic logic [47:0] bytes_at(input int start, input int len);
        logic [47:0] v;
        v = '0;
        for (int i = 0; i < len; i++)
            v = {v[39:0], cap[start + i]};
        return v;
    endfunction

    function automatic logic [15:0] ones_sum(input int start, input int len);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < len; i += 2)
            s += {16'h0, cap[start + i], (i + 1 < len) ? cap[start + i + 1] : 8'h00};
        while (s[31:16] != '0)
            s = {16'h0, s[31:16]} + {16'h0, s[15:0]};    // end-around carry
        return s[15:0];
    endfunction

    function automatic logic [31:0] payload_sum(input int n);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < n; i += 2)
            s += {16'h0, payload[i], (i + 1 < n) ? payload[i + 1] : 8'h00};
        return s;
    endfunction

    // reflected crc-32, poly edb88320
    function automatic logic [31:0] crc32_ref(input int first, input int last);
        logic [31:0] c;
        c = 32'hffff_ffff;
        for (int i = first; i <= last; i++) begin
            c ^= {24'h0, cap[i]};
            for (int b = 0; b < 8; b++)
                c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
        return ~c;
    endfunction

    task automatic run_echo(input string name, input int n,
                            input logic [47:0] mac_in, input logic [31:0] ip_in,
                            input logic [47:0] exp_mac, input logic [31:0] exp_ip,
                            input logic [15:0] exp_ident,
                            input logic [15:0] id, input logic [15:0] seq);
        int          start_errors;
        int          body;
        int          total;
        logic [31:0] rnd;
        start_errors = errors;
        payload.delete();
        for (int i = 0; i < n; i++) begin
            @(posedge gmii_tx_clk);
            #1;
            rnd = $random(seed);
            payload.push_back(rnd[7:0]);
            payload_data = rnd[7:0];
            payload_wr   = 1'b1;
        end
        @(posedge gmii_tx_clk);
        #1;
        payload_wr  = 1'b0;
        cap.delete();
        tx_byte_num = 16'(n);
        dst_mac     = mac_in;
        dst_ip      = ip_in;
        icmp_id     = id;
        icmp_seq    = seq;
        data_sum    = payload_sum(n);
        tx_start    = 1'b1;
        @(posedge gmii_tx_clk);
        #1;
        tx_start = 1'b0;
        @(negedge gmii_tx_clk);
        check_equal({name, " busy after start"}, 48'h1, {47'h0, busy});
        while (!tx_done)
            @(negedge gmii_tx_clk);
        check_equal({name, " busy at done"}, 48'h0, {47'h0, busy});

        body  = (n > 18) ? n : 18;    // short payloads get zero padded
        total = 8 + 14 + 28 + body + 4;
        check_equal({name, " frame length"}, 48'(total), 48'(cap.size()));
        if (cap.size() == total) begin
            for (int i = 0; i < 7; i++)
                check_equal({name, " preamble"}, 48'h55, {40'h0, cap[i]});
            check_equal({name, " sfd"}, 48'hd5, {40'h0, cap[7]});
            check_equal({name, " dst mac"}, exp_mac, bytes_at(8, 6));
            check_equal({name, " src mac"}, board_mac, bytes_at(14, 6));
            check_equal({name, " ethertype"}, 48'h0800, bytes_at(20, 2));
            check_equal({name, " ip total length"}, 48'(n + 28), bytes_at(24, 2));
            check_equal({name, " ip ident"}, {32'h0, exp_ident}, bytes_at(26, 2));
            check_equal({name, " src ip"}, {16'h0, board_ip}, bytes_at(34, 4));
            check_equal({name, " dst ip"}, {16'h0, exp_ip}, bytes_at(38, 4));
            check_equal({name, " ip checksum"}, 48'hffff, {32'h0, ones_sum(22, 20)});
            check_equal({name, " icmp type"}, 48'h0, bytes_at(42, 1));
            check_equal({name, " icmp id"}, {32'h0, id}, bytes_at(46, 2));
            check_equal({name, " icmp seq"}, {32'h0, seq}, bytes_at(48, 2));
            check_equal({name, " icmp checksum"}, 48'hffff, {32'h0, ones_sum(42, 8 + n)});
            for (int i = 0; i < n; i++)
                check_equal({name, " payload"}, {40'h0, payload[i]}, bytes_at(50 + i, 1));
            for (int i = n; i < body; i++)
                check_equal({name, " pad"}, 48'h0, bytes_at(50 + i, 1));
            // fcs goes out low byte first
            check_equal({name, " fcs"}, {16'h0, crc32_ref(8, total - 5)},
                        {16'h0, cap[total - 1], cap[total - 2], cap[total - 3], cap[total - 4]});
        end
        report_test(name, start_errors);
    endtask

    initial begin
        int start_errors;
        gmii_tx_clk  = 1'b0;
        rst          = 1'b1;
        tx_start     = 1'b0;
        tx_byte_num  = 16'h0;
        dst_mac      = 48'h0;
        dst_ip       = 32'h0;
        icmp_id      = 16'h0;
        icmp_seq     = 16'h0;
        data_sum     = 32'h0;
        payload_data = 8'h0;
        payload_wr   = 1'b0;

        start_errors = errors;
        repeat (10) @(negedge gmii_tx_clk);
        check_equal("reset gmii_tx_en", 48'h0, {47'h0, gmii_tx_en});
        check_equal("reset tx_done", 48'h0, {47'h0, tx_done});
        check_equal("reset busy", 48'h0, {47'h0, busy});
        check_equal("reset payload_full", 48'h0, {47'h0, payload_full});
        report_test("reset", start_errors);
        @(posedge gmii_tx_clk);
        #1;
        rst = 1'b0;

        run_echo("pad_short", 5, 48'h02_00_00_de_ad_01, {8'd10, 8'd0, 8'd0, 8'd77},
                 48'h02_00_00_de_ad_01, {8'd10, 8'd0, 8'd0, 8'd77}, 16'd1, 16'h1234, 16'd7);
        run_echo("no_pad", 40, 48'h02_00_00_de_ad_02, {8'd10, 8'd0, 8'd1, 8'd5},
                 48'h02_00_00_de_ad_02, {8'd10, 8'd0, 8'd1, 8'd5}, 16'd2, 16'hbeef, 16'd8);
        run_echo("defaults", 23, 48'h0, 32'h0,
                 default_dst_mac, default_dst_ip, 16'd3, 16'h00a5, 16'hfffe);

        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // --------------------
    // watchdog
    initial begin
        repeat (num_frames * 150 + 50) @(posedge gmii_tx_clk);
        $display("watchdog expired before all frames completed");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
hw/net_proto_pkg.sv
hw/gmii_frame_pkg.sv
hw/echo_hdr_if.sv
hw/echo_header_builder.sv
hw/payload_fifo.sv
hw/gmii_frame_tx.sv
hw/icmp_echo_tx.sv
verification/icmp_echo_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icmp echo testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module icmp_echo_tx_tb -o icmp_echo_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/icmp_echo_tx_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
